/* rtl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Address of the first instruction fetched after reset
`define RESET_VECTOR 32'h0000_0000

// An "or" into register 0, which has no effect
`define INSN_NOOP 32'h0000_0000

// Instruction memory holds 2**IMEM_ADDR_BITS words
`define IMEM_ADDR_BITS 8

`endif

/* rtl/busPkg.sv */
`default_nettype none

package busPkg;

    // One data word on the memory buses
    typedef logic [31:0] word_t;

    // Word address, not byte address
    typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [3:0] regIndex_t;

    localparam regIndex_t regZero = 4'd0;     // Always reads zero
    localparam regIndex_t regPc   = 4'd15;    // Reads next instruction address

    // Bit positions inside an instruction word
    localparam int formBit  = 30;
    localparam int storeBit = 29;
    localparam int derefBit = 28;
    localparam int zLsb     = 24;
    localparam int xLsb     = 20;
    localparam int yLsb     = 16;
    localparam int opLsb    = 12;
    localparam int immLsb   = 0;
    localparam int immWidth = 12;

    typedef enum logic [3:0] {
        opOr     = 4'd0,  opAnd    = 4'd1,  opAdd   = 4'd2,  opMul    = 4'd3,
        opRsvd4  = 4'd4,  opShl    = 4'd5,  opLt    = 4'd6,  opEq     = 4'd7,
        opGt     = 4'd8,  opAndNot = 4'd9,  opXor   = 4'd10, opSub    = 4'd11,
        opXnor   = 4'd12, opShr    = 4'd13, opNe    = 4'd14, opRsvd15 = 4'd15
    } aluOp_t;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             en,
    input  logic             writeEnable,
    input  isaPkg::regIndex_t indexX,
    input  isaPkg::regIndex_t indexY,
    input  isaPkg::regIndex_t indexZ,
    input  busPkg::word_t    writeData,
    input  busPkg::word_t    nextPc,
    output busPkg::word_t    valueX,
    output busPkg::word_t    valueY,
    output busPkg::word_t    valueZ
);

    busPkg::word_t regs [1:14];    // Only the general-purpose entries

    function automatic busPkg::word_t readReg(input isaPkg::regIndex_t index);
        busPkg::word_t value;
        if (index == isaPkg::regZero)
            value = '0;
        else if (index == isaPkg::regPc)
            value = nextPc;
        else
            value = regs[index];
        return value;
    endfunction

    assign valueX = readReg(indexX);
    assign valueY = readReg(indexY);
    assign valueZ = readReg(indexZ);

    always_ff @(posedge clk) begin
        if (en && writeEnable && indexZ != isaPkg::regZero && indexZ != isaPkg::regPc) begin
            regs[indexZ] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* rtl/insnDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module insnDecoder (
    input  busPkg::word_t     insn,
    output isaPkg::regIndex_t indexZ,
    output isaPkg::regIndex_t indexX,
    output isaPkg::regIndex_t indexY,
    output isaPkg::aluOp_t    op,
    output busPkg::word_t     imm,
    output logic              immForm,
    output logic              storing,
    output logic              deref,
    output logic              branch,
    output logic              illegal
);

    logic [isaPkg::immWidth-1:0] immField;

    assign immForm = insn[isaPkg::formBit];     // 1: immediate is the right operand
    assign storing = insn[isaPkg::storeBit];
    assign deref   = insn[isaPkg::derefBit];
    assign indexZ  = insn[isaPkg::zLsb +: 4];
    assign indexX  = insn[isaPkg::xLsb +: 4];
    assign indexY  = insn[isaPkg::yLsb +: 4];
    assign op      = isaPkg::aluOp_t'(insn[isaPkg::opLsb +: 4]);

    assign immField = insn[isaPkg::immLsb +: isaPkg::immWidth];
    assign imm      = {{(32 - isaPkg::immWidth){immField[isaPkg::immWidth-1]}}, immField};

    // Writing the next-address register redirects the fetch
    assign branch  = (indexZ == isaPkg::regPc) && !storing;
    assign illegal = &insn;

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  logic           clk,
    input  logic           en,
    input  isaPkg::aluOp_t op,
    input  busPkg::word_t  x,
    input  busPkg::word_t  y,
    input  busPkg::word_t  addend,
    output busPkg::word_t  result
);

    logic signed [31:0] sx;
    logic signed [31:0] sy;
    logic [4:0]         shamt;
    busPkg::word_t      opValue;

    assign sx    = x;
    assign sy    = y;
    assign shamt = y[4:0];    // Shift by 0..31 only

    always_comb begin
        case (op)
            isaPkg::opOr:     opValue = x | y;
            isaPkg::opAnd:    opValue = x & y;
            isaPkg::opAdd:    opValue = x + y;
            isaPkg::opMul:    opValue = x * y;          // Low half of the product
            isaPkg::opShl:    opValue = x << shamt;
            isaPkg::opLt:     opValue = {32{sx < sy}};
            isaPkg::opEq:     opValue = {32{x == y}};
            isaPkg::opGt:     opValue = {32{sx > sy}};
            isaPkg::opAndNot: opValue = x & ~y;
            isaPkg::opXor:    opValue = x ^ y;
            isaPkg::opSub:    opValue = x - y;
            isaPkg::opXnor:   opValue = x ^~ y;
            isaPkg::opShr:    opValue = x >> shamt;     // Logical, zero fill
            isaPkg::opNe:     opValue = {32{x != y}};
            isaPkg::opRsvd4,
            isaPkg::opRsvd15: opValue = '0;
            default:          opValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= opValue + addend;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpuCore.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCore (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          haltReq,
    output logic          halted,
    output busPkg::addr_t insnAddr,
    input  busPkg::word_t insnData,
    output logic          memStrobe,
    output logic          memWrite,
    output busPkg::word_t memAddr,
    output busPkg::word_t memWdata,
    input  busPkg::word_t memRdata
);

    logic [3:0]        phase;        // One-hot, all zero when idle
    logic [3:0]        phaseNext;
    busPkg::word_t     insn;
    busPkg::addr_t     nextPc;
    busPkg::addr_t     targetAddr;
    busPkg::word_t     commitData;

    isaPkg::regIndex_t indexZ, indexX, indexY;
    isaPkg::aluOp_t    op;
    busPkg::word_t     imm;
    logic              immForm, storing, deref, branch, illegal, loading;
    busPkg::word_t     valueX, valueY, valueZ;
    busPkg::word_t     aluY, aluAddend, aluResult, rhs;

    always_comb begin
        phaseNext = {phase[2:0], 1'b0};
        if (phase == 4'b0000)
            phaseNext = (haltReq || halted) ? 4'b0000 : 4'b0001;  // Wait out a pause
        else if (phase[1] && illegal)
            phaseNext = 4'b0000;                                  // Stop for good
        else if (phase[3])
            phaseNext = haltReq ? 4'b0000 : 4'b0001;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase    <= 4'b0000;    // First cycle out of reset is idle
            halted   <= 1'b0;
            insn     <= `INSN_NOOP;
            insnAddr <= `RESET_VECTOR;
            nextPc   <= `RESET_VECTOR + 1;
        end else begin
            phase <= phaseNext;
            if (phase[0])
                insn <= insnData;    // Fetch
            if (phase[1] && illegal)
                halted <= 1'b1;
            if (phase[2]) begin
                insnAddr <= targetAddr;
                nextPc   <= targetAddr + 1;
            end
        end
    end

    // Load data must be held past the strobe cycle
    always_ff @(posedge clk) begin
        if (phase[2])
            commitData <= rhs;
    end

    insnDecoder u_decoder (
        .insn    (insn),    .indexZ  (indexZ),  .indexX  (indexX),
        .indexY  (indexY),  .op      (op),      .imm     (imm),
        .immForm (immForm), .storing (storing), .deref   (deref),
        .branch  (branch),  .illegal (illegal)
    );

    assign aluY      = immForm ? imm    : valueY;
    assign aluAddend = immForm ? valueY : imm;

    alu u_alu (
        .clk    (clk),  .en     (phase[1]),  .op     (op),
        .x      (valueX), .y    (aluY),      .addend (aluAddend),
        .result (aluResult)
    );

    assign loading    = deref && !storing;
    assign memStrobe  = phase[2] && (storing || loading);
    assign memWrite   = phase[2] && storing;
    assign memAddr    = deref ? aluResult : valueZ;
    assign memWdata   = deref ? valueZ    : aluResult;
    assign rhs        = deref ? memRdata  : aluResult;
    assign targetAddr = branch ? rhs : nextPc;

    regFile u_regs (
        .clk       (clk),        .en          (phase[3]), .writeEnable (!storing),
        .indexX    (indexX),     .indexY      (indexY),   .indexZ      (indexZ),
        .writeData (commitData), .nextPc      (nextPc),
        .valueX    (valueX),     .valueY      (valueY),   .valueZ      (valueZ)
    );

endmodule

`default_nettype wire

/* rtl/insnMemory.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module insnMemory #(
    parameter int addrBits = `IMEM_ADDR_BITS
) (
    input  logic          clk,
    input  logic          hostWrite,
    input  busPkg::addr_t hostAddr,
    input  busPkg::word_t hostData,
    input  busPkg::addr_t readAddr,
    output busPkg::word_t readData
);

    busPkg::word_t mem [2**addrBits];

    // Upper address bits are ignored, so the space wraps
    always_ff @(posedge clk) begin
        if (hostWrite) begin
            mem[hostAddr[addrBits-1:0]] <= hostData;
        end
        readData <= mem[readAddr[addrBits-1:0]];    // One-cycle read latency
    end

endmodule

`default_nettype wire

/* rtl/cpuSystem.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuSystem (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          haltReq,
    input  logic          hostWrite,
    input  busPkg::addr_t hostAddr,
    input  busPkg::word_t hostData,
    output logic          halted,
    output logic          memStrobe,
    output logic          memWrite,
    output busPkg::word_t memAddr,
    output busPkg::word_t memWdata,
    input  busPkg::word_t memRdata
);

    busPkg::addr_t insnAddr;
    busPkg::word_t insnData;

    cpuCore u_core (
        .clk       (clk),       .reset_n  (reset_n),  .haltReq  (haltReq),
        .halted    (halted),    .insnAddr (insnAddr), .insnData (insnData),
        .memStrobe (memStrobe), .memWrite (memWrite), .memAddr  (memAddr),
        .memWdata  (memWdata),  .memRdata (memRdata)
    );

    // Host port only loads while the core sits in reset
    insnMemory #(
        .addrBits (`IMEM_ADDR_BITS)
    ) u_imem (
        .clk       (clk),
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostData  (hostData),
        .readAddr  (insnAddr),
        .readData  (insnData)
    );

endmodule

`default_nettype wire

/* verif/tbCpuSystem.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tbCpuSystem;

    localparam int progWords   = 16;    // One program per reset, loaded while in reset
    localparam int numPrograms = 4;
    localparam int pauseCycles = 10;
    localparam int dataBits    = 8;
    localparam int watchdogCycles = numPrograms * (progWords + 2 + progWords * 4 + 16)
                                    + pauseCycles + 40;
    localparam busPkg::word_t illegalWord = 32'hFFFF_FFFF;

    logic          clk, reset_n, haltReq, hostWrite, halted, memStrobe, memWrite;
    busPkg::addr_t hostAddr;
    busPkg::word_t hostData, memAddr, memWdata, memRdata;

    busPkg::word_t dataMem  [2**dataBits];
    busPkg::word_t modelMem [2**dataBits];
    logic          expWrite [$];
    busPkg::word_t expAddr [$];
    busPkg::word_t expData [$];
    logic          wantWrite;
    busPkg::word_t wantAddr, wantData;
    busPkg::word_t lcgState = 32'ha093;
    int            totalExpected = 0;
    int            accessesChecked = 0;

    cpuSystem u_dut (
        .clk       (clk),       .reset_n  (reset_n),  .haltReq  (haltReq),
        .hostWrite (hostWrite), .hostAddr (hostAddr), .hostData (hostData),
        .halted    (halted),    .memStrobe(memStrobe), .memWrite (memWrite),
        .memAddr   (memAddr),   .memWdata (memWdata), .memRdata (memRdata)
    );

    assign memRdata = dataMem[memAddr[dataBits-1:0]];    // Combinational data memory

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun();
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic failCheck(input string what);
        $display("%0t: %s", $time, what);
        stopRun();
    endtask

    task automatic checkWord(input string name, input busPkg::word_t got, want);
        assert (got === want) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
            stopRun();
        end
    endtask

    function automatic logic [11:0] randomImm();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[27:16];    // Upper bits vary more
    endfunction

    function automatic busPkg::word_t encode(input logic form, store, deref,
            input isaPkg::regIndex_t z, x, y, input logic [3:0] op, input logic [11:0] imm);
        busPkg::word_t w;
        w = '0;
        w[isaPkg::formBit]  = form;
        w[isaPkg::storeBit] = store;
        w[isaPkg::derefBit] = deref;
        w[isaPkg::zLsb +: 4] = z;
        w[isaPkg::xLsb +: 4] = x;
        w[isaPkg::yLsb +: 4] = y;
        w[isaPkg::opLsb +: 4] = op;
        w[isaPkg::immLsb +: isaPkg::immWidth] = imm;
        return w;
    endfunction

    function automatic busPkg::word_t aluModel(input logic [3:0] op, input busPkg::word_t a, b);
        case (op)
            4'd0:    return a | b;
            4'd1:    return a & b;
            4'd2:    return a + b;
            4'd3:    return a * b;
            4'd5:    return a << b[4:0];
            4'd6:    return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            4'd7:    return (a == b) ? 32'hFFFF_FFFF : 32'h0;
            4'd8:    return ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'h0;
            4'd9:    return a & ~b;
            4'd10:   return a ^ b;
            4'd11:   return a - b;
            4'd12:   return ~(a ^ b);
            4'd13:   return a >> b[4:0];
            4'd14:   return (a != b) ? 32'hFFFF_FFFF : 32'h0;
            default: return 32'h0;    // Reserved codes 4 and 15
        endcase
    endfunction

    // Runs the program on a model and queues every memory access it makes
    task automatic predictStores(input busPkg::word_t prog [$]);
        busPkg::word_t regs [16];
        busPkg::word_t insn, imm, x, y, z, rhs, nextPc, pc;
        isaPkg::regIndex_t zi;
        int steps;
        pc = `RESET_VECTOR;
        steps = 0;
        modelMem = dataMem;
        regs[0] = '0;
        while (prog[pc] != illegalWord && steps < progWords) begin
            insn = prog[pc];
            nextPc = pc + 1;
            regs[15] = nextPc;
            imm = {{(32 - isaPkg::immWidth){insn[isaPkg::immWidth-1]}},
                   insn[isaPkg::immWidth-1:0]};
            zi = insn[isaPkg::zLsb +: 4];
            x = regs[insn[isaPkg::xLsb +: 4]];
            y = regs[insn[isaPkg::yLsb +: 4]];
            z = regs[zi];
            if (insn[isaPkg::formBit])
                rhs = aluModel(insn[isaPkg::opLsb +: 4], x, imm) + y;
            else
                rhs = aluModel(insn[isaPkg::opLsb +: 4], x, y) + imm;
            if (insn[isaPkg::derefBit] && !insn[isaPkg::storeBit]) begin
                expWrite.push_back(1'b0);    // Load
                expAddr.push_back(rhs);
                expData.push_back('0);
                totalExpected++;
                rhs = modelMem[rhs[dataBits-1:0]];
            end
            if (insn[isaPkg::storeBit]) begin
                expWrite.push_back(1'b1);
                expAddr.push_back(insn[isaPkg::derefBit] ? rhs : z);
                expData.push_back(insn[isaPkg::derefBit] ? z : rhs);
                modelMem[expAddr[$][dataBits-1:0]] = expData[$];
                totalExpected++;
            end else if (zi == 4'd15) begin
                nextPc = rhs;    // Branch
            end else if (zi != 4'd0) begin
                regs[zi] = rhs;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    task automatic runProgram(input busPkg::word_t prog [$], input logic withPause);
        predictStores(prog);
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        for (int i = 0; i < progWords; i++) begin
            hostWrite = 1'b1;
            hostAddr  = i;
            hostData  = (i < prog.size()) ? prog[i] : `INSN_NOOP;
            @(posedge clk);
            #1;
        end
        hostWrite = 1'b0;
        reset_n   = 1'b1;
        checkWord("{memStrobe,memWrite,halted}", {29'b0, memStrobe, memWrite, halted}, '0);
        if (withPause) begin
            repeat (9) @(posedge clk);
            #1;
            haltReq = 1'b1;
            repeat (pauseCycles) @(posedge clk);
            #1;
            haltReq = 1'b0;
        end
        wait (halted === 1'b1);
        repeat (12) @(posedge clk);    // Quiet bus expected after the illegal word
        assert (expAddr.size() == 0) else failCheck("a predicted memory access never appeared");
    endtask

    always @(negedge clk) begin
        if (reset_n && memStrobe) begin
            assert (expAddr.size() > 0)
                else failCheck("memory access seen that the model did not make");
            wantWrite = expWrite.pop_front();
            wantAddr  = expAddr.pop_front();
            wantData  = expData.pop_front();
            checkWord("memWrite", {31'b0, memWrite}, {31'b0, wantWrite});
            checkWord("memAddr", memAddr, wantAddr);
            if (memWrite) begin
                checkWord("memWdata", memWdata, wantData);
                dataMem[memAddr[dataBits-1:0]] = memWdata;
            end
            accessesChecked++;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
            memStrobe |-> !$past(memStrobe) && !$past(memStrobe, 2) && !$past(memStrobe, 3))
        else failCheck("memStrobe came back less than four cycles after the last strobe");
    assert property (@(posedge clk) disable iff (!reset_n) halted |-> !memStrobe)
        else failCheck("memStrobe high while halted");
    assert property (@(posedge clk) disable iff (!reset_n) memWrite |-> memStrobe)
        else failCheck("memWrite high without memStrobe");
    // Five cycles of haltReq always span an instruction boundary
    assert property (@(posedge clk) disable iff (!reset_n)
            haltReq && $past(haltReq) && $past(haltReq, 2) && $past(haltReq, 3)
            && $past(haltReq, 4) |-> !memStrobe)
        else failCheck("memStrobe during a haltReq pause");

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        failCheck("watchdog expired before the last program halted");
    end

    initial begin
        busPkg::word_t prog [$];
        int c;
        logic [11:0] imm1;
        reset_n   = 1'b0;
        haltReq   = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostData  = '0;
        for (int i = 0; i < 2**dataBits; i++)
            dataMem[i] = (i * 32'h0101_0101) ^ 32'h5A3C_0000;
        for (int p = 0; p < 3; p++) begin    // All sixteen codes in both forms
            prog.delete();
            imm1 = randomImm();
            prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, imm1));
            prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd2, 4'd0, 4'd0, 4'd0,
                                  (p == 0) ? imm1 : randomImm()));    // Equal operands once
            prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd3, 4'd0, 4'd0, 4'd0, 12'h040 + 12'(p)));
            for (int k = 0; k < 12; k++) begin
                c = p * 12 + k;
                if (c < 32)
                    prog.push_back(encode(c[4], 1'b1, 1'b0, 4'd3, 4'd1, 4'd2, c[3:0], randomImm()));
            end
            prog.push_back(illegalWord);
            runProgram(prog, p == 1);
        end
        prog.delete();    // Loads, register 0 and 15, branch
        prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, 12'h010));
        prog.push_back(encode(1'b1, 1'b0, 1'b1, 4'd2, 4'd1, 4'd0, 4'd2, 12'h000));
        prog.push_back(encode(1'b1, 1'b0, 1'b1, 4'd3, 4'd1, 4'd0, 4'd2, 12'h001));
        prog.push_back(encode(1'b0, 1'b0, 1'b0, 4'd4, 4'd2, 4'd3, 4'd10, 12'h005));
        prog.push_back(encode(1'b1, 1'b1, 1'b1, 4'd4, 4'd1, 4'd0, 4'd2, 12'h002));
        prog.push_back(encode(1'b0, 1'b0, 1'b0, 4'd0, 4'd4, 4'd0, 4'd0, 12'h000));
        prog.push_back(encode(1'b0, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, 12'h000));
        prog.push_back(encode(1'b0, 1'b1, 1'b0, 4'd1, 4'd15, 4'd0, 4'd0, 12'h000));
        prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, 4'd2, 12'h002));
        prog.push_back(encode(1'b1, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, 12'h7FF));
        prog.push_back(encode(1'b1, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, 12'h7FE));
        prog.push_back(encode(1'b1, 1'b0, 1'b1, 4'd5, 4'd1, 4'd0, 4'd2, 12'h002));
        prog.push_back(encode(1'b0, 1'b1, 1'b0, 4'd1, 4'd5, 4'd0, 4'd0, 12'h000));
        prog.push_back(illegalWord);
        prog.push_back(encode(1'b1, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 4'd0, 12'h123));
        runProgram(prog, 1'b0);
        if (accessesChecked == totalExpected && totalExpected > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            failCheck("number of memory accesses differs from the model");
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/busPkg.sv
rtl/isaPkg.sv
rtl/regFile.sv
rtl/insnDecoder.sv
rtl/alu.sv
rtl/cpuCore.sv
rtl/insnMemory.sv
rtl/cpuSystem.sv
verif/tbCpuSystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpuSystem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
